// ==== filelist.f ====
verilog/rename_pkg.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/br_stack.sv
verilog/rename_unit.sv
dv/rename_unit_assert.sv
dv/rename_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module rename_unit_tb \
    -f filelist.f \
    -o rename_unit_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/rename_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== dv/rename_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_unit_tb import rename_pkg::*; ();

    logic       clock;
    logic       reset;
    logic       dis_valid;
    arch_reg_t  dis_src1;
    arch_reg_t  dis_src2;
    logic       dis_has_dest;
    arch_reg_t  dis_dest;
    logic       dis_is_branch;
    addr_t      dis_pc;
    rob_idx_t   dis_rob_tail;
    logic       cdb_valid;
    phys_reg_t  cdb_preg;
    logic       retire_valid;
    phys_reg_t  retire_preg;
    br_task_t   br_task;
    b_id_t      rem_b_id;

    phys_reg_t  src1_preg;
    logic       src1_ready;
    phys_reg_t  src2_preg;
    logic       src2_ready;
    phys_reg_t  dest_preg;
    phys_reg_t  old_preg;
    b_id_t      assigned_b_id;
    logic       full;
    logic       free_empty;
    logic       recover;
    addr_t      rec_pc;
    rob_idx_t   rec_rob_tail;

    // reference model
    phys_reg_t  m_tag [ARCH_REGS];
    logic       m_rdy [ARCH_REGS];
    phys_reg_t  fl_seq [$];                 // every tag ever put on the free list, in order
    int         fl_head;                    // next one handed out
    phys_reg_t  pool [$];                   // old tags waiting to retire
    int         pool_base;                  // old tags retired so far
    logic       cp_valid [BR_DEPTH];        // slot i carries branch id 1 << i
    b_id_t      cp_mask [BR_DEPTH];
    phys_reg_t  cp_tag [BR_DEPTH][ARCH_REGS];
    logic       cp_rdy [BR_DEPTH][ARCH_REGS];
    int         cp_head [BR_DEPTH];
    int         cp_pool [BR_DEPTH];         // old tags issued before the branch
    addr_t      cp_pc [BR_DEPTH];
    rob_idx_t   cp_rob [BR_DEPTH];

    int errors;
    int checks;
    int tests;
    int test_err0;
    int assert_fails;
    int waited;
    int pick;
    phys_reg_t t;
    b_id_t id;

    rename_unit u_rename_unit (.*);

    bind rename_unit rename_unit_assert u_rename_unit_assert (
        .clock         (clock),
        .reset         (reset),
        .dis_valid     (dis_valid),
        .dis_is_branch (dis_is_branch),
        .dis_has_dest  (dis_has_dest),
        .full          (full),
        .free_empty    (free_empty),
        .recover       (recover)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic report_stall(input string what);
        $display("%s at %0t", what, $time);
        errors++;
    endtask

    task automatic idle_inputs();
        dis_valid     = 1'b0;
        dis_src1      = '0;
        dis_src2      = '0;
        dis_has_dest  = 1'b0;
        dis_dest      = '0;
        dis_is_branch = 1'b0;
        dis_pc        = '0;
        dis_rob_tail  = '0;
        cdb_valid     = 1'b0;
        cdb_preg      = '0;
        retire_valid  = 1'b0;
        retire_preg   = '0;
        br_task       = BR_NONE;
        rem_b_id      = '0;
    endtask

    task automatic model_reset();
        fl_seq.delete();
        pool.delete();
        fl_head   = 0;
        pool_base = 0;
        for (int a = 0; a < ARCH_REGS; a++) begin
            m_tag[a] = phys_reg_t'(a);
            m_rdy[a] = 1'b1;
        end
        for (int i = 0; i < FREE_SLOTS; i++) begin
            fl_seq.push_back(phys_reg_t'(ARCH_REGS + i));
        end
        for (int i = 0; i < BR_DEPTH; i++) begin
            cp_valid[i] = 1'b0;
        end
    endtask

    function automatic b_id_t lowest_free();
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (!cp_valid[i]) return b_id_t'(1 << i);
        end
        return '0;
    endfunction

    function automatic int slot_of(input b_id_t bid);
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (bid[i]) return i;
        end
        return -1;
    endfunction

    // only tags older than every open branch retire, and a retire
    // may not overrun the slots that a squash could hand back
    function automatic bit can_retire();
        int minh;
        int oldest;
        minh   = fl_head;
        oldest = pool_base + pool.size();
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (cp_valid[i] && cp_head[i] < minh) minh = cp_head[i];
            if (cp_valid[i] && cp_pool[i] < oldest) oldest = cp_pool[i];
        end
        return pool_base < oldest && fl_seq.size() - minh < FREE_SLOTS;
    endfunction

    function automatic phys_reg_t retire_oldest();
        pool_base++;
        return pool.pop_front();
    endfunction

    // compare mid-cycle, then step the model at the rising edge
    task automatic cycle();
        int        slot;
        int        sq;
        b_id_t     live;
        phys_reg_t nt [ARCH_REGS];
        logic      nr [ARCH_REGS];
        @(negedge clock);
        check("src1_preg", 32'(src1_preg), 32'(m_tag[dis_src1]));
        check("src1_ready", 32'(src1_ready), 32'(m_rdy[dis_src1]));
        check("src2_preg", 32'(src2_preg), 32'(m_tag[dis_src2]));
        check("src2_ready", 32'(src2_ready), 32'(m_rdy[dis_src2]));
        check("old_preg", 32'(old_preg), 32'(m_tag[dis_dest]));
        check("free_empty", 32'(free_empty), 32'(fl_head == fl_seq.size()));
        if (fl_head < fl_seq.size()) check("dest_preg", 32'(dest_preg), 32'(fl_seq[fl_head]));
        check("full", 32'(full), 32'(lowest_free() == '0));
        check("assigned_b_id", 32'(assigned_b_id),
              32'((dis_valid && dis_is_branch) ? lowest_free() : b_id_t'(0)));
        check("recover", 32'(recover), 32'(br_task == BR_SQUASH));
        sq = slot_of(rem_b_id);
        if (br_task == BR_SQUASH && sq >= 0) begin
            check("rec_pc", rec_pc, cp_pc[sq]);
            check("rec_rob_tail", 32'(rec_rob_tail), 32'(cp_rob[sq]));
        end

        @(posedge clock);
        slot = slot_of(lowest_free());     // allocation sees the stack before this edge
        for (int a = 0; a < ARCH_REGS; a++) begin
            nt[a] = (br_task == BR_SQUASH) ? cp_tag[sq][a] : m_tag[a];
            nr[a] = (br_task == BR_SQUASH) ? cp_rdy[sq][a] : m_rdy[a];
            if (cdb_valid && nt[a] == cdb_preg) nr[a] = 1'b1;
            for (int i = 0; i < BR_DEPTH; i++) begin
                if (cdb_valid && cp_tag[i][a] == cdb_preg) cp_rdy[i][a] = 1'b1;
            end
        end
        if (br_task == BR_SQUASH) begin
            fl_head = cp_head[sq];
            while (pool.size() > 0 && pool_base + pool.size() > cp_pool[sq]) begin
                void'(pool.pop_back());    // squashed instructions never retire
            end
        end else if (dis_valid && dis_has_dest) begin
            pool.push_back(m_tag[dis_dest]);
            nt[dis_dest] = fl_seq[fl_head];
            nr[dis_dest] = 1'b0;
            fl_head++;
        end
        if (retire_valid) fl_seq.push_back(retire_preg);

        for (int i = 0; i < BR_DEPTH; i++) begin
            if (sq >= 0 && br_task == BR_SQUASH && (i == sq || cp_mask[i][sq])) begin
                cp_valid[i] = 1'b0;    // the branch and all younger ones
            end else if (sq >= 0 && br_task == BR_CLEAR) begin
                if (i == sq) cp_valid[i] = 1'b0;
                else cp_mask[i][sq] = 1'b0;
            end
        end
        live = '0;
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (cp_valid[i]) live[i] = 1'b1;
        end
        if (dis_valid && dis_is_branch && br_task != BR_SQUASH && slot >= 0) begin
            cp_valid[slot] = 1'b1;
            cp_mask[slot]  = live;
            cp_head[slot]  = fl_head;
            cp_pool[slot]  = pool_base + pool.size();
            cp_pc[slot]    = dis_pc;
            cp_rob[slot]   = dis_rob_tail;
        end
        for (int a = 0; a < ARCH_REGS; a++) begin
            m_tag[a] = nt[a];
            m_rdy[a] = nr[a];
            if (dis_valid && dis_is_branch && br_task != BR_SQUASH && slot >= 0) begin
                cp_tag[slot][a] = nt[a];
                cp_rdy[slot][a] = nr[a];
            end
        end
        #1;
    endtask

    task automatic rename(input arch_reg_t dest, input arch_reg_t s1, input arch_reg_t s2);
        dis_valid    = 1'b1;
        dis_has_dest = 1'b1;
        dis_dest     = dest;
        dis_src1     = s1;
        dis_src2     = s2;
        cycle();
        idle_inputs();
    endtask

    task automatic branch(input addr_t pc, input rob_idx_t rob);
        dis_valid     = 1'b1;
        dis_is_branch = 1'b1;
        dis_pc        = pc;
        dis_rob_tail  = rob;
        cycle();
        idle_inputs();
    endtask

    task automatic resolve(input br_task_t cmd, input b_id_t bid);
        br_task  = cmd;
        rem_b_id = bid;
        cycle();
        idle_inputs();
    endtask

    task automatic refill();
        for (int n = 0; n < 2 * FREE_SLOTS && can_retire(); n++) begin
            retire_valid = 1'b1;
            retire_preg  = retire_oldest();
            cycle();
            idle_inputs();
        end
    endtask

    task automatic read_map();
        for (int k = 0; k < ARCH_REGS / 2; k++) begin
            dis_src1 = arch_reg_t'(2 * k);
            dis_src2 = arch_reg_t'(2 * k + 1);
            dis_dest = arch_reg_t'(k);
            cycle();
        end
        idle_inputs();
    endtask

    task automatic clear_all();
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (cp_valid[i]) resolve(BR_CLEAR, b_id_t'(1 << i));
        end
    endtask

    task automatic start_test();
        test_err0 = errors;
    endtask

    task automatic finish_test(input string name);
        errors += u_rename_unit.u_rename_unit_assert.fail_count - assert_fails;
        assert_fails = u_rename_unit.u_rename_unit_assert.fail_count;
        tests++;
        $display("test %0d %s %s (%0d errors)", tests, name,
                 (errors == test_err0) ? "ok" : "failed", errors - test_err0);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        tests        = 0;
        assert_fails = 0;
        void'($urandom(32'h4198_b286));
        idle_inputs();
        reset = 1'b1;
        model_reset();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test();
        for (int a = 0; a < ARCH_REGS; a++) begin
            dis_src1 = arch_reg_t'(a);
            dis_src2 = arch_reg_t'(ARCH_REGS - 1 - a);
            cycle();
        end
        idle_inputs();
        finish_test("reset state");

        start_test();
        for (int n = 0; n < 4; n++) begin
            rename(arch_reg_t'(1), arch_reg_t'(1), arch_reg_t'(n));
        end
        refill();       // the four old tags fit back
        waited = 0;
        while (!free_empty && waited < 12) begin
            rename(arch_reg_t'(waited % ARCH_REGS), arch_reg_t'(1), arch_reg_t'(2));
            waited++;
        end
        if (!free_empty) report_stall("free list never ran empty");
        cycle();
        finish_test("rename order");

        start_test();
        refill();
        rename(arch_reg_t'(2), arch_reg_t'(2), arch_reg_t'(0));
        cdb_valid = 1'b1;
        cdb_preg  = m_tag[2];
        dis_src1  = arch_reg_t'(2);
        cycle();
        idle_inputs();
        dis_src1 = arch_reg_t'(2);
        cycle();                                    // ready from here on
        rename(arch_reg_t'(5), arch_reg_t'(5), arch_reg_t'(2));
        t  = m_tag[5];
        id = lowest_free();
        branch(32'h0000_0100, 5'd3);
        cdb_valid = 1'b1;
        cdb_preg  = t;                              // wakes the stored checkpoint
        cycle();
        idle_inputs();
        rename(arch_reg_t'(5), arch_reg_t'(5), arch_reg_t'(5));
        resolve(BR_SQUASH, id);
        read_map();
        rename(arch_reg_t'(3), arch_reg_t'(3), arch_reg_t'(3));
        id = lowest_free();
        cdb_valid = 1'b1;
        cdb_preg  = m_tag[3];                       // same cycle as the checkpoint
        branch(32'h0000_0200, 5'd4);
        rename(arch_reg_t'(3), arch_reg_t'(3), arch_reg_t'(1));
        resolve(BR_SQUASH, id);
        read_map();
        finish_test("wakeup");

        start_test();
        refill();
        rename(arch_reg_t'(4), arch_reg_t'(4), arch_reg_t'(5));
        id = lowest_free();
        branch(32'h0000_2a40, 5'd17);
        for (int n = 0; n < 3; n++) begin
            rename(arch_reg_t'(n + 4), arch_reg_t'(4), arch_reg_t'(n));
        end
        resolve(BR_SQUASH, id);
        read_map();
        finish_test("squash");

        start_test();
        refill();
        for (int n = 0; n < BR_DEPTH; n++) begin
            branch(addr_t'(32'h0000_3000 + 4 * n), rob_idx_t'(n));
        end
        waited = 0;
        while (!full && waited < 4) begin
            cycle();
            waited++;
        end
        if (!full) report_stall("branch stack never filled");
        resolve(BR_SQUASH, 4'b0010);
        branch(32'h0000_3100, 5'd20);               // lowest free id again
        resolve(BR_CLEAR, 4'b0001);
        branch(32'h0000_3200, 5'd21);
        branch(32'h0000_3300, 5'd22);               // second slot still held
        clear_all();
        finish_test("nested");

        start_test();
        for (int n = 0; n < 300; n++) begin
            pick = $urandom % BR_DEPTH;
            for (int i = 0; i < BR_DEPTH && !cp_valid[pick]; i++) begin
                pick = (pick + 1) % BR_DEPTH;
            end
            if (!cp_valid[pick]) pick = -1;
            if ($urandom % 8 == 0 && pick >= 0) begin
                br_task  = BR_SQUASH;
                rem_b_id = b_id_t'(1 << pick);
            end else begin
                if ($urandom % 8 == 0 && pick >= 0) begin
                    br_task  = BR_CLEAR;
                    rem_b_id = b_id_t'(1 << pick);
                end
                dis_valid     = $urandom % 4 != 0;
                dis_is_branch = $urandom % 4 == 0 && lowest_free() != '0;
                dis_has_dest  = !dis_is_branch && $urandom % 4 != 0 && fl_head < fl_seq.size();
                dis_src1      = arch_reg_t'($urandom);
                dis_src2      = arch_reg_t'($urandom);
                dis_dest      = arch_reg_t'($urandom);
                dis_pc        = $urandom;
                dis_rob_tail  = rob_idx_t'($urandom);
            end
            cdb_valid = $urandom % 3 == 0;
            cdb_preg  = phys_reg_t'($urandom);
            if ($urandom % 3 == 0 && can_retire()) begin
                retire_valid = 1'b1;
                retire_preg  = retire_oldest();
            end
            cycle();
            idle_inputs();
        end
        clear_all();
        finish_test("random mix");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rename_unit_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_unit_assert (
    input wire logic     clock,
    input wire logic     reset,
    input wire logic     dis_valid,
    input wire logic     dis_is_branch,
    input wire logic     dis_has_dest,
    input wire logic     full,
    input wire logic     free_empty,
    input wire logic     recover
);

    int fail_count = 0;     // failed assertions so far

    // environment rules
    no_dispatch_in_squash: assert property (@(posedge clock) disable iff (reset)
        recover |-> !dis_valid)
        else begin
            $error("instruction dispatched in a squash cycle");
            fail_count++;
        end

    no_branch_when_full: assert property (@(posedge clock) disable iff (reset)
        (dis_valid && dis_is_branch) |-> !full)
        else begin
            $error("branch dispatched while the branch stack is full");
            fail_count++;
        end

    no_rename_when_empty: assert property (@(posedge clock) disable iff (reset)
        (dis_valid && dis_has_dest) |-> !free_empty)
        else begin
            $error("rename while the free list is empty");
            fail_count++;
        end

    // branch stack behavior
    squash_frees_a_slot: assert property (@(posedge clock) disable iff (reset)
        recover |=> !full)
        else begin
            $error("branch stack still full after a squash");
            fail_count++;
        end

    reset_state: assert property (@(posedge clock)
        reset |=> (!full && !free_empty))
        else begin
            $error("wrong branch stack or free list state after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verilog/rename_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_unit import rename_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,

    // dispatch
    input  wire logic       dis_valid,
    input  wire arch_reg_t  dis_src1,
    input  wire arch_reg_t  dis_src2,
    input  wire logic       dis_has_dest,
    input  wire arch_reg_t  dis_dest,
    input  wire logic       dis_is_branch,
    input  wire addr_t      dis_pc,
    input  wire rob_idx_t   dis_rob_tail,

    input  wire logic       cdb_valid,
    input  wire phys_reg_t  cdb_preg,
    input  wire logic       retire_valid,
    input  wire phys_reg_t  retire_preg,
    input  wire br_task_t   br_task,
    input  wire b_id_t      rem_b_id,

    // rename results
    output phys_reg_t       src1_preg,
    output logic            src1_ready,
    output phys_reg_t       src2_preg,
    output logic            src2_ready,
    output phys_reg_t       dest_preg,
    output phys_reg_t       old_preg,

    output b_id_t           assigned_b_id,
    output logic            full,
    output logic            free_empty,
    output logic            recover,
    output addr_t           rec_pc,
    output rob_idx_t        rec_rob_tail
);

    map_snap_t map_next;
    map_snap_t rec_map;
    fl_ptr_t   fl_head_next;
    fl_ptr_t   rec_fl_head;
    logic      rename_pop;

    assign rename_pop = dis_valid & dis_has_dest;

    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .dis_valid    (dis_valid),
        .dis_has_dest (dis_has_dest),
        .dis_src1     (dis_src1),
        .dis_src2     (dis_src2),
        .dis_dest     (dis_dest),
        .new_preg     (dest_preg),
        .cdb_valid    (cdb_valid),
        .cdb_preg     (cdb_preg),
        .recover      (recover),
        .rec_map      (rec_map),
        .src1_preg    (src1_preg),
        .src1_ready   (src1_ready),
        .src2_preg    (src2_preg),
        .src2_ready   (src2_ready),
        .old_preg     (old_preg),
        .map_next     (map_next)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .pop          (rename_pop),
        .retire_valid (retire_valid),
        .retire_preg  (retire_preg),
        .recover      (recover),
        .rec_fl_head  (rec_fl_head),
        .head_preg    (dest_preg),
        .fl_head_next (fl_head_next),
        .free_empty   (free_empty)
    );

    br_stack u_br_stack (
        .clock         (clock),
        .reset         (reset),
        .dis_valid     (dis_valid),
        .dis_is_branch (dis_is_branch),
        .dis_pc        (dis_pc),
        .dis_rob_tail  (dis_rob_tail),
        .map_next      (map_next),
        .fl_head_next  (fl_head_next),
        .cdb_valid     (cdb_valid),
        .cdb_preg      (cdb_preg),
        .br_task       (br_task),
        .rem_b_id      (rem_b_id),
        .assigned_b_id (assigned_b_id),
        .full          (full),
        .recover       (recover),
        .rec_map       (rec_map),
        .rec_fl_head   (rec_fl_head),
        .rec_pc        (rec_pc),
        .rec_rob_tail  (rec_rob_tail)
    );

endmodule

`default_nettype wire

// ==== verilog/br_stack.sv ====
`timescale 1ns/100ps
`default_nettype none

module br_stack import rename_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,

    input  wire logic       dis_valid,
    input  wire logic       dis_is_branch,
    input  wire addr_t      dis_pc,
    input  wire rob_idx_t   dis_rob_tail,

    input  wire map_snap_t  map_next,
    input  wire fl_ptr_t    fl_head_next,

    input  wire logic       cdb_valid,
    input  wire phys_reg_t  cdb_preg,

    input  wire br_task_t   br_task,
    input  wire b_id_t      rem_b_id,       // branch being resolved

    output b_id_t           assigned_b_id,
    output logic            full,
    output logic            recover,
    output map_snap_t       rec_map,
    output fl_ptr_t         rec_fl_head,
    output addr_t           rec_pc,
    output rob_idx_t        rec_rob_tail
);

    // control part of each checkpoint
    logic [BR_DEPTH-1:0] ent_valid;
    b_id_t               ent_b_id   [BR_DEPTH];
    b_id_t               ent_b_mask [BR_DEPTH];  // older branches this one depends on

    // payload part
    map_snap_t           ent_map      [BR_DEPTH];
    fl_ptr_t             ent_fl_head  [BR_DEPTH];
    addr_t               ent_pc       [BR_DEPTH];
    rob_idx_t            ent_rob_tail [BR_DEPTH];

    logic [BR_DEPTH-1:0] next_valid;
    b_id_t               next_b_id   [BR_DEPTH];
    b_id_t               next_b_mask [BR_DEPTH];

    b_id_t               free_slots;
    b_id_t               gnt;
    b_id_t               live_ids;
    logic                alloc;

    // lowest free slot, its one-hot position is also the branch id
    assign free_slots = ~ent_valid;
    assign gnt        = free_slots & (~free_slots + b_id_t'(1));

    assign full    = &ent_valid;
    assign recover = (br_task == BR_SQUASH);
    assign alloc   = dis_valid && dis_is_branch && !full && !recover;

    assign assigned_b_id = (dis_valid && dis_is_branch) ? gnt : '0;

    // recovery values of the squashed checkpoint
    always_comb begin
        rec_map      = '0;
        rec_fl_head  = '0;
        rec_pc       = '0;
        rec_rob_tail = '0;
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (ent_valid[i] && ent_b_id[i] == rem_b_id) begin
                rec_map      = ent_map[i];
                rec_fl_head  = ent_fl_head[i];
                rec_pc       = ent_pc[i];
                rec_rob_tail = ent_rob_tail[i];
            end
        end
    end

    always_comb begin
        next_valid = ent_valid;
        for (int i = 0; i < BR_DEPTH; i++) begin
            next_b_id[i]   = ent_b_id[i];
            next_b_mask[i] = ent_b_mask[i];
        end

        for (int i = 0; i < BR_DEPTH; i++) begin
            if (ent_valid[i]) begin
                if (br_task == BR_SQUASH) begin
                    // the branch itself and everything younger goes
                    if (ent_b_id[i] == rem_b_id || |(ent_b_mask[i] & rem_b_id)) begin
                        next_valid[i] = 1'b0;
                    end
                end else if (br_task == BR_CLEAR) begin
                    if (ent_b_id[i] == rem_b_id) begin
                        next_valid[i] = 1'b0;
                    end else begin
                        next_b_mask[i] = ent_b_mask[i] & ~rem_b_id;
                    end
                end
            end
        end

        // a new branch depends on every branch still open after this cycle
        live_ids = '0;
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (next_valid[i]) begin
                live_ids = live_ids | ent_b_id[i];
            end
        end

        for (int i = 0; i < BR_DEPTH; i++) begin
            if (alloc && gnt[i]) begin
                next_valid[i]  = 1'b1;
                next_b_id[i]   = gnt;
                next_b_mask[i] = live_ids;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
            for (int i = 0; i < BR_DEPTH; i++) begin
                ent_b_id[i]   <= '0;
                ent_b_mask[i] <= '0;
            end
        end else begin
            ent_valid <= next_valid;
            for (int i = 0; i < BR_DEPTH; i++) begin
                ent_b_id[i]   <= next_b_id[i];
                ent_b_mask[i] <= next_b_mask[i];
            end
        end
    end

    // map_next already carries this cycle's wakeup, stored maps get theirs here
    always_ff @(posedge clock) begin
        for (int i = 0; i < BR_DEPTH; i++) begin
            if (alloc && gnt[i]) begin
                ent_map[i]      <= map_next;
                ent_fl_head[i]  <= fl_head_next;
                ent_pc[i]       <= dis_pc;
                ent_rob_tail[i] <= dis_rob_tail;
            end else if (cdb_valid) begin
                ent_map[i] <= snap_wakeup(ent_map[i], cdb_preg);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,

    input  wire logic       pop,            // rename with a destination
    input  wire logic       retire_valid,
    input  wire phys_reg_t  retire_preg,

    input  wire logic       recover,
    input  wire fl_ptr_t    rec_fl_head,

    output phys_reg_t       head_preg,
    output fl_ptr_t         fl_head_next,
    output logic            free_empty
);

    phys_reg_t slots [FREE_SLOTS];

    fl_ptr_t head;
    fl_ptr_t tail;
    fl_ptr_t head_d;
    fl_ptr_t tail_d;

    logic do_pop;

    // a squash cycle carries no rename
    assign do_pop = pop && !recover;

    assign head_preg  = slots[head[FL_IDX_W-1:0]];
    assign free_empty = (head == tail);

    always_comb begin
        if (recover) begin
            head_d = rec_fl_head;       // allocations after the branch come back
        end else if (do_pop) begin
            head_d = head + fl_ptr_t'(1);
        end else begin
            head_d = head;
        end

        // retirement is never undone, tail only moves forward
        tail_d = retire_valid ? tail + fl_ptr_t'(1) : tail;
    end

    assign fl_head_next = head_d;

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= fl_ptr_t'(FREE_SLOTS);  // same slot, other lap: list is full
        end else begin
            head <= head_d;
            tail <= tail_d;
        end
    end

    // the slots start out holding the unmapped tags in order
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_SLOTS; i++) begin
                slots[i] <= phys_reg_t'(ARCH_REGS + i);
            end
        end else if (retire_valid) begin
            slots[tail[FL_IDX_W-1:0]] <= retire_preg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module map_table import rename_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset,

    input  wire logic       dis_valid,
    input  wire logic       dis_has_dest,
    input  wire arch_reg_t  dis_src1,
    input  wire arch_reg_t  dis_src2,
    input  wire arch_reg_t  dis_dest,
    input  wire phys_reg_t  new_preg,      // head of the free list

    input  wire logic       cdb_valid,
    input  wire phys_reg_t  cdb_preg,

    input  wire logic       recover,
    input  wire map_snap_t  rec_map,

    output phys_reg_t       src1_preg,
    output logic            src1_ready,
    output phys_reg_t       src2_preg,
    output logic            src2_ready,
    output phys_reg_t       old_preg,
    output map_snap_t       map_next       // state after this edge, for checkpoints
);

    map_snap_t map_q;
    map_snap_t map_d;

    // arch reg i maps to phys reg i, all ready
    function automatic map_snap_t identity_map();
        map_snap_t ident;
        ident = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            ident[i*MAP_ENTRY_W +: PREG_W]   = phys_reg_t'(i);
            ident[i*MAP_ENTRY_W + PREG_W]    = 1'b1;
        end
        return ident;
    endfunction

    // lookups read the registered map, so sources see the
    // mapping from before this instruction's own destination
    assign src1_preg  = snap_tag(map_q, dis_src1);
    assign src1_ready = snap_ready(map_q, dis_src1);
    assign src2_preg  = snap_tag(map_q, dis_src2);
    assign src2_ready = snap_ready(map_q, dis_src2);
    assign old_preg   = snap_tag(map_q, dis_dest);

    always_comb begin
        map_d = recover ? rec_map : map_q;

        // wakeup also lands on a restored map
        if (cdb_valid) begin
            map_d = snap_wakeup(map_d, cdb_preg);
        end

        if (!recover && dis_valid && dis_has_dest) begin
            map_d[dis_dest*MAP_ENTRY_W +: MAP_ENTRY_W] = {1'b0, new_preg}; // new tag not ready
        end
    end

    assign map_next = map_d;

    always_ff @(posedge clock) begin
        if (reset) begin
            map_q <= identity_map();
        end else begin
            map_q <= map_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // core sizes
    localparam int ARCH_REGS  = 8;
    localparam int PHYS_REGS  = 16;
    localparam int FREE_SLOTS = PHYS_REGS - ARCH_REGS;
    localparam int BR_DEPTH   = 4;

    // derived widths
    localparam int AREG_W      = $clog2(ARCH_REGS);
    localparam int PREG_W      = $clog2(PHYS_REGS);
    localparam int FL_IDX_W    = $clog2(FREE_SLOTS);
    localparam int ADDR_W      = 32;
    localparam int ROB_IDX_W   = 5;
    localparam int MAP_ENTRY_W = PREG_W + 1;   // tag plus ready bit

    typedef logic [AREG_W-1:0]                  arch_reg_t;
    typedef logic [PREG_W-1:0]                  phys_reg_t;
    typedef logic [FL_IDX_W:0]                  fl_ptr_t;    // slot index with wrap bit on top
    typedef logic [BR_DEPTH-1:0]                b_id_t;      // one-hot id or branch mask
    typedef logic [ADDR_W-1:0]                  addr_t;
    typedef logic [ROB_IDX_W-1:0]               rob_idx_t;
    typedef logic [ARCH_REGS*MAP_ENTRY_W-1:0]   map_snap_t;

    // entry i of a map_snap_t sits at bits [i*MAP_ENTRY_W +: MAP_ENTRY_W]
    // with the tag in the low PREG_W bits and the ready bit above it

    typedef logic [1:0] br_task_t;

    localparam br_task_t BR_NONE   = 2'd0;
    localparam br_task_t BR_CLEAR  = 2'd1;
    localparam br_task_t BR_SQUASH = 2'd2;

    // set the ready bit of every entry holding the broadcast tag
    function automatic map_snap_t snap_wakeup(map_snap_t snap, phys_reg_t tag);
        map_snap_t woken;
        woken = snap;
        for (int i = 0; i < ARCH_REGS; i++) begin
            if (snap[i*MAP_ENTRY_W +: PREG_W] == tag) begin
                woken[i*MAP_ENTRY_W + PREG_W] = 1'b1;
            end
        end
        return woken;
    endfunction

    // tag field of one entry
    function automatic phys_reg_t snap_tag(map_snap_t snap, arch_reg_t areg);
        return snap[areg*MAP_ENTRY_W +: PREG_W];
    endfunction

    // ready bit of one entry
    function automatic logic snap_ready(map_snap_t snap, arch_reg_t areg);
        return snap[areg*MAP_ENTRY_W + PREG_W];
    endfunction

endpackage

`default_nettype wire
